/* project.f */
logic/periph_pkg.sv
logic/obi_to_reg.sv
logic/reg_demux.sv
logic/gpio_regs.sv
logic/timer_regs.sv
logic/irq_ctrl.sv
logic/peripheral_subsystem.sv
test/peripheral_subsystem_props.sv
test/tb_peripheral_subsystem.sv

/* Bender.yml */
package:
  name: peripheral_subsystem

sources:
  - logic/periph_pkg.sv
  - logic/obi_to_reg.sv
  - logic/reg_demux.sv
  - logic/gpio_regs.sv
  - logic/timer_regs.sv
  - logic/irq_ctrl.sv
  - logic/peripheral_subsystem.sv
  - target: test
    files:
      - test/peripheral_subsystem_props.sv
      - test/tb_peripheral_subsystem.sv

/* test/tb_peripheral_subsystem.sv */
// Testbench for the peripheral subsystem
// Drives OBI transfers, GPIO pins and external lines, checks reads and interrupts
module tb_peripheral_subsystem;
  import periph_pkg::*;

  localparam int GpioWidth     = 16;
  localparam int NumExtIrq     = 8;
  localparam int TimeoutCycles = 2000;
  localparam int TimerId       = GpioWidth + 1;
  localparam int ExtBase       = GpioWidth + 2;
  localparam logic [31:0] GpioMask  = (32'd1 << GpioWidth) - 1;
  localparam logic [31:0] GpioBase  = 32'h0000_0000;
  localparam logic [31:0] TimerBase = 32'h0000_0100;
  localparam logic [31:0] IrqBase   = 32'h0000_0200;

  logic                 clk;
  logic                 rst_n;
  logic                 req;
  logic [31:0]          addr;
  logic                 we;
  logic [3:0]           be;
  logic [31:0]          wdata;
  logic                 gnt;
  logic                 rvalid;
  logic [31:0]          rdata;
  logic                 err;
  logic [GpioWidth-1:0] gpio_in;
  logic [GpioWidth-1:0] gpio_out;
  logic [GpioWidth-1:0] gpio_en;
  logic [NumExtIrq-1:0] intr_ext;
  logic                 irq;
  logic                 msip;
  logic [31:0]          seed;
  int                   err_cnt;
  int                   cycles;

  peripheral_subsystem #(
    .GpioWidth (GpioWidth),
    .NumExtIrq (NumExtIrq)
  ) UUT (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .req_i      (req),
    .addr_i     (addr),
    .we_i       (we),
    .be_i       (be),
    .wdata_i    (wdata),
    .gnt_o      (gnt),
    .rvalid_o   (rvalid),
    .rdata_o    (rdata),
    .err_o      (err),
    .gpio_i     (gpio_in),
    .gpio_o     (gpio_out),
    .gpio_en_o  (gpio_en),
    .intr_ext_i (intr_ext),
    .irq_o      (irq),
    .msip_o     (msip)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("Test failed");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Expected register word after a byte-enabled write
  function automatic logic [31:0] apply_be(input logic [31:0] old_w, input logic [31:0] new_w,
                                           input logic [3:0] b);
    logic [31:0] mask;
    mask = {{8{b[3]}}, {8{b[2]}}, {8{b[1]}}, {8{b[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else begin
      err_cnt++;
      $display("[ERROR] %s expected 0x%h got 0x%h", name, exp, act);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // Called on a rising edge, returns on the edge that samples the response
  task automatic bus_access(input logic [31:0] a, input logic wr, input logic [3:0] b,
                            input logic [31:0] d, output logic [31:0] rd, output logic er);
    req   <= 1'b1;
    addr  <= a;
    we    <= wr;
    be    <= b;
    wdata <= d;
    @(posedge clk);
    while (!gnt) @(posedge clk);
    req <= 1'b0;
    @(posedge clk);
    while (!rvalid) @(posedge clk);
    rd = rdata;
    er = err;
  endtask

  task automatic write_reg(input logic [31:0] a, input logic [31:0] d, input logic [3:0] b);
    logic [31:0] rd;
    logic        er;
    bus_access(a, 1'b1, b, d, rd, er);
    expect_eq("err_o", 32'd0, 32'(er));
  endtask

  task automatic read_check(input logic [31:0] a, input logic [31:0] exp, input string name);
    logic [31:0] rd;
    logic        er;
    bus_access(a, 1'b0, 4'hF, 32'd0, rd, er);
    expect_eq("err_o", 32'd0, 32'(er));
    expect_eq(name, exp, rd);
  endtask

  task automatic wait_for_irq(input int limit, input string what);
    int n;
    n = 0;
    while (!irq && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (!irq) begin
      err_cnt++;
      $display("irq_o did not rise within %0d cycles for the %s", limit, what);
    end
  endtask

  initial begin
    logic [31:0] d;
    logic [31:0] r;
    logic [31:0] rd;
    logic [31:0] exp_out;
    logic [31:0] exp_oen;
    logic [31:0] ien;
    logic [31:0] pat;
    logic [31:0] clr;
    logic [31:0] cmp;
    logic [3:0]  b;
    logic        er;
    int          pa;
    int          pb;
    int          k;

    seed     = 32'hda46_aeed;
    err_cnt  = 0;
    rst_n    = 1'b0;
    req      = 1'b0;
    addr     = '0;
    we       = 1'b0;
    be       = '0;
    wdata    = '0;
    gpio_in  = '0;
    intr_ext = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // GPIO outputs with full and partial byte enables
    exp_out = '0;
    exp_oen = '0;
    for (int i = 0; i < 6; i++) begin
      r = next_rand();
      b = (i < 2) ? 4'hF : r[3:0];
      d = next_rand();
      exp_out = apply_be(exp_out, d, b) & GpioMask;
      write_reg(GpioBase + GpioDataOut, d, b);
      expect_eq("gpio_o", exp_out, 32'(gpio_out));
      read_check(GpioBase + GpioDataOut, exp_out, "DATA_OUT");
      d = next_rand();
      exp_oen = apply_be(exp_oen, d, b) & GpioMask;
      write_reg(GpioBase + GpioOutEn, d, b);
      expect_eq("gpio_en_o", exp_oen, 32'(gpio_en));
      read_check(GpioBase + GpioOutEn, exp_oen, "OUT_EN");
    end

    // Input synchronizer and edge status
    r = next_rand();
    gpio_in <= r[GpioWidth-1:0];
    wait_cycles(3);
    read_check(GpioBase + GpioDataIn, r & GpioMask, "DATA_IN");
    ien = next_rand() & GpioMask;
    write_reg(GpioBase + GpioIntrEn, ien, 4'hF);
    gpio_in <= '0;
    wait_cycles(4);
    write_reg(GpioBase + GpioIntrStatus, GpioMask, 4'hF);
    pat = next_rand() & GpioMask;
    gpio_in <= pat[GpioWidth-1:0];
    wait_cycles(4);
    read_check(GpioBase + GpioIntrStatus, pat & ien, "INTR_STATUS");
    clr = next_rand() & GpioMask;
    write_reg(GpioBase + GpioIntrStatus, clr, 4'hF);
    read_check(GpioBase + GpioIntrStatus, pat & ien & ~clr, "INTR_STATUS");
    write_reg(GpioBase + GpioIntrStatus, GpioMask, 4'hF);
    read_check(GpioBase + GpioIntrStatus, 32'd0, "INTR_STATUS");

    // GPIO interrupts through claim and complete
    pa = int'(next_rand() % (GpioWidth / 2));
    pb = GpioWidth / 2 + int'(next_rand() % (GpioWidth / 2));
    gpio_in <= '0;
    wait_cycles(4);
    write_reg(GpioBase + GpioIntrEn, (32'd1 << pa) | (32'd1 << pb), 4'hF);
    write_reg(GpioBase + GpioIntrStatus, GpioMask, 4'hF);
    write_reg(IrqBase + IrqEnable, (32'd1 << (pa + 1)) | (32'd1 << (pb + 1)), 4'hF);
    gpio_in <= GpioWidth'((32'd1 << pa) | (32'd1 << pb));
    wait_for_irq(6, "GPIO edges");
    read_check(IrqBase + IrqPending, (32'd1 << (pa + 1)) | (32'd1 << (pb + 1)), "PENDING");
    read_check(IrqBase + IrqClaim, 32'(pa + 1), "CLAIM");
    expect_eq("irq_o", 32'd1, 32'(irq));
    read_check(IrqBase + IrqClaim, 32'(pb + 1), "CLAIM");
    expect_eq("irq_o", 32'd0, 32'(irq));
    // Sources still high but in service
    read_check(IrqBase + IrqPending, 32'd0, "PENDING");
    write_reg(GpioBase + GpioIntrStatus, GpioMask, 4'hF);
    write_reg(IrqBase + IrqClaim, 32'(pa + 1), 4'hF);
    write_reg(IrqBase + IrqClaim, 32'(pb + 1), 4'hF);
    read_check(IrqBase + IrqPending, 32'd0, "PENDING");
    gpio_in <= '0;
    wait_cycles(4);
    gpio_in <= GpioWidth'(32'd1 << pa);
    wait_for_irq(6, "re-armed GPIO source");
    read_check(IrqBase + IrqClaim, 32'(pa + 1), "CLAIM");
    write_reg(GpioBase + GpioIntrStatus, GpioMask, 4'hF);
    write_reg(IrqBase + IrqClaim, 32'(pa + 1), 4'hF);
    gpio_in <= '0;

    // Timer compare, then one external line
    cmp = 32'd20 + (next_rand() & 32'hF);
    write_reg(TimerBase + TimerCompare, cmp, 4'hF);
    write_reg(TimerBase + TimerCount, 32'd0, 4'hF);
    write_reg(IrqBase + IrqEnable, 32'd1 << TimerId, 4'hF);
    write_reg(TimerBase + TimerCtrl, 32'd1, 4'hF);
    wait_for_irq(int'(cmp) + 3, "timer");
    read_check(IrqBase + IrqPending, 32'd1 << TimerId, "PENDING");
    read_check(IrqBase + IrqClaim, 32'(TimerId), "CLAIM");
    write_reg(TimerBase + TimerCtrl, 32'd0, 4'hF);
    write_reg(IrqBase + IrqClaim, 32'(TimerId), 4'hF);
    read_check(IrqBase + IrqPending, 32'd0, "PENDING");
    k = int'(next_rand() % NumExtIrq);
    write_reg(IrqBase + IrqEnable, 32'd1 << (ExtBase + k), 4'hF);
    intr_ext <= NumExtIrq'(32'd1 << k);
    wait_for_irq(4, "external line");
    read_check(IrqBase + IrqClaim, 32'(ExtBase + k), "CLAIM");
    intr_ext <= '0;
    write_reg(IrqBase + IrqClaim, 32'(ExtBase + k), 4'hF);
    read_check(IrqBase + IrqPending, 32'd0, "PENDING");
    expect_eq("irq_o", 32'd0, 32'(irq));

    // Decode errors and software interrupt
    bus_access(32'h0000_0300, 1'b0, 4'hF, 32'd0, rd, er);
    expect_eq("err_o", 32'd1, 32'(er));
    expect_eq("rdata_o", 32'd0, rd);
    bus_access(32'h0000_0304, 1'b1, 4'hF, next_rand(), rd, er);
    expect_eq("err_o", 32'd1, 32'(er));
    expect_eq("rdata_o", 32'd0, rd);
    bus_access(32'h0000_1000, 1'b0, 4'hF, 32'd0, rd, er);
    expect_eq("err_o", 32'd1, 32'(er));
    expect_eq("rdata_o", 32'd0, rd);
    write_reg(IrqBase + IrqMsip, 32'd1, 4'hF);
    expect_eq("msip_o", 32'd1, 32'(msip));
    read_check(IrqBase + IrqMsip, 32'd1, "MSIP");
    write_reg(IrqBase + IrqMsip, 32'd0, 4'hF);
    expect_eq("msip_o", 32'd0, 32'(msip));
    wait_cycles(2);

    $display("Checks done: %0d data errors, %0d assertion failures", err_cnt,
             UUT.u_props.fail_cnt);
    if (err_cnt == 0 && UUT.u_props.fail_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* test/peripheral_subsystem_props.sv */
// Bus timing and reset-state assertions for the peripheral subsystem
// Bound into every peripheral_subsystem instance
module peripheral_subsystem_props #(
  parameter int unsigned GpioWidth = 16
) (
  input logic                             clk_i,
  input logic                             rst_n_i,
  input logic                             req_i,
  input logic                             we_i,
  input logic                             gnt_i,
  input logic                             rvalid_i,
  input logic [periph_pkg::DataWidth-1:0] rdata_i,
  input logic                             err_i,
  input logic [GpioWidth-1:0]             gpio_out_i,
  input logic [GpioWidth-1:0]             gpio_en_i,
  input logic                             irq_i,
  input logic                             msip_i,
  input logic                             timer_en_i
);
  int fail_cnt = 0;

  // Response exactly one cycle after acceptance
  assert property (@(posedge clk_i) disable iff (!rst_n_i) (req_i && gnt_i) |=> rvalid_i)
  else begin
    fail_cnt++;
    $error("rvalid_o missing one cycle after an accepted request");
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) rvalid_i |-> $past(req_i && gnt_i))
  else begin
    fail_cnt++;
    $error("rvalid_o high without an accepted request in the previous cycle");
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   (rvalid_i && $past(req_i && we_i)) |-> (rdata_i == '0))
  else begin
    fail_cnt++;
    $error("write response carries nonzero read data");
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) err_i |-> rvalid_i)
  else begin
    fail_cnt++;
    $error("err_o high outside a response");
  end

  assert property (@(posedge clk_i) gnt_i |-> req_i)
  else begin
    fail_cnt++;
    $error("gnt_o high without req_i");
  end

  // Outputs cleared by the synchronous reset
  assert property (@(posedge clk_i) !rst_n_i |=> (!rvalid_i && !err_i && gpio_out_i == '0 &&
                   gpio_en_i == '0 && !irq_i && !msip_i && !timer_en_i))
  else begin
    fail_cnt++;
    $error("control outputs not low during reset");
  end

endmodule

bind peripheral_subsystem peripheral_subsystem_props #(
  .GpioWidth (GpioWidth)
) u_props (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .req_i      (req_i),
  .we_i       (we_i),
  .gnt_i      (gnt_o),
  .rvalid_i   (rvalid_o),
  .rdata_i    (rdata_o),
  .err_i      (err_o),
  .gpio_out_i (gpio_o),
  .gpio_en_i  (gpio_en_o),
  .irq_i      (irq_o),
  .msip_i     (msip_o),
  .timer_en_i (u_timer_regs.en_q)
);

/* logic/peripheral_subsystem.sv */
// Peripheral subsystem top level
// OBI bridge, register demux, GPIO, timer and interrupt controller
module peripheral_subsystem #(
  parameter int unsigned GpioWidth = 16,
  parameter int unsigned NumExtIrq = 8
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             req_i,
  input  logic [periph_pkg::AddrWidth-1:0] addr_i,
  input  logic                             we_i,
  input  logic [periph_pkg::BeWidth-1:0]   be_i,
  input  logic [periph_pkg::DataWidth-1:0] wdata_i,
  output logic                             gnt_o,
  output logic                             rvalid_o,
  output logic [periph_pkg::DataWidth-1:0] rdata_o,
  output logic                             err_o,
  input  logic [GpioWidth-1:0]             gpio_i,
  output logic [GpioWidth-1:0]             gpio_o,
  output logic [GpioWidth-1:0]             gpio_en_o,
  input  logic [NumExtIrq-1:0]             intr_ext_i,
  output logic                             irq_o,
  output logic                             msip_o
);
  import periph_pkg::*;

  localparam int unsigned NumSrc = GpioWidth + NumExtIrq + 2;

  logic                                  reg_valid;
  logic [AddrWidth-1:0]                  reg_addr;
  logic                                  reg_we;
  logic [BeWidth-1:0]                    reg_be;
  logic [DataWidth-1:0]                  reg_wdata;
  logic [DataWidth-1:0]                  reg_rdata;
  logic                                  reg_err;
  logic [NumRegions-1:0]                 sel_valid;
  logic [NumRegions-1:0][DataWidth-1:0]  sel_rdata;
  logic [GpioWidth-1:0]                  gpio_intr;
  logic                                  timer_intr;
  logic [NumSrc-1:0]                     intr_vector;

  // Source 0 is reserved and tied low
  assign intr_vector[0]                                    = 1'b0;
  assign intr_vector[GpioWidth:1]                          = gpio_intr;
  assign intr_vector[timer_src_id(GpioWidth)]              = timer_intr;
  assign intr_vector[ext_src_base(GpioWidth)+:NumExtIrq]   = intr_ext_i;

  obi_to_reg u_obi_to_reg (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .addr_i      (addr_i),
    .we_i        (we_i),
    .be_i        (be_i),
    .wdata_i     (wdata_i),
    .gnt_o       (gnt_o),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .err_o       (err_o),
    .reg_valid_o (reg_valid),
    .reg_addr_o  (reg_addr),
    .reg_we_o    (reg_we),
    .reg_be_o    (reg_be),
    .reg_wdata_o (reg_wdata),
    .reg_rdata_i (reg_rdata),
    .reg_err_i   (reg_err)
  );

  reg_demux u_reg_demux (
    .reg_valid_i (reg_valid),
    .reg_addr_i  (reg_addr),
    .reg_rdata_o (reg_rdata),
    .reg_err_o   (reg_err),
    .sel_valid_o (sel_valid),
    .sel_rdata_i (sel_rdata)
  );

  gpio_regs #(
    .GpioWidth (GpioWidth)
  ) u_gpio_regs (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .valid_i   (sel_valid[GpioRegion]),
    .addr_i    (reg_addr[RegionSelLsb-1:0]),
    .we_i      (reg_we),
    .be_i      (reg_be),
    .wdata_i   (reg_wdata),
    .rdata_o   (sel_rdata[GpioRegion]),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_en_o (gpio_en_o),
    .intr_o    (gpio_intr)
  );

  timer_regs u_timer_regs (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (sel_valid[TimerRegion]),
    .addr_i  (reg_addr[RegionSelLsb-1:0]),
    .we_i    (reg_we),
    .be_i    (reg_be),
    .wdata_i (reg_wdata),
    .rdata_o (sel_rdata[TimerRegion]),
    .intr_o  (timer_intr)
  );

  irq_ctrl #(
    .NumSrc (NumSrc)
  ) u_irq_ctrl (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (sel_valid[IrqRegion]),
    .addr_i  (reg_addr[RegionSelLsb-1:0]),
    .we_i    (reg_we),
    .wdata_i (reg_wdata),
    .rdata_o (sel_rdata[IrqRegion]),
    .src_i   (intr_vector),
    .irq_o   (irq_o),
    .msip_o  (msip_o)
  );

endmodule

/* logic/irq_ctrl.sv */
// Platform interrupt controller
// Gateways, enable mask, claim/complete and a software interrupt bit
module irq_ctrl #(
  parameter int unsigned NumSrc = 26
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                valid_i,
  input  logic [periph_pkg::RegionSelLsb-1:0] addr_i,
  input  logic                                we_i,
  input  logic [periph_pkg::DataWidth-1:0]    wdata_i,
  output logic [periph_pkg::DataWidth-1:0]    rdata_o,
  input  logic [NumSrc-1:0]                   src_i,
  output logic                                irq_o,
  output logic                                msip_o
);
  import periph_pkg::*;

  logic [NumSrc-1:0]     enable_q;
  logic [NumSrc-1:0]     pending_q;
  logic [NumSrc-1:0]     in_service_q;
  logic                  msip_q;
  logic [MaxSources-1:0] pend_en;
  logic [IrqIdWidth-1:0] claim_id;
  logic [NumSrc-1:0]     set_mask;
  logic [NumSrc-1:0]     claim_mask;
  logic [NumSrc-1:0]     complete_mask;
  logic                  claim_rd;
  logic                  claim_wr;

  assign pend_en  = MaxSources'(pending_q & enable_q);
  assign claim_rd = valid_i & ~we_i & (addr_i == IrqClaim);
  assign claim_wr = valid_i & we_i & (addr_i == IrqClaim);

  // Lowest pending enabled ID, source 0 never wins
  always_comb begin
    claim_id = '0;
    for (int i = MaxSources - 1; i > 0; i--) begin
      if (pend_en[i]) claim_id = IrqIdWidth'(i);
    end
  end

  // Gateway holds off a source while it is in service
  assign set_mask      = src_i & enable_q & ~in_service_q & {{(NumSrc-1){1'b1}}, 1'b0};
  assign claim_mask    = claim_rd ? NumSrc'(MaxSources'(1) << claim_id) : '0;
  assign complete_mask = claim_wr ? NumSrc'(MaxSources'(1) << wdata_i[IrqIdWidth-1:0]) : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      enable_q     <= '0;
      pending_q    <= '0;
      in_service_q <= '0;
      msip_q       <= 1'b0;
    end else begin
      pending_q    <= (pending_q | set_mask) & ~claim_mask;
      in_service_q <= (in_service_q | claim_mask) & ~complete_mask;
      if (valid_i && we_i && addr_i == IrqEnable) begin
        enable_q <= wdata_i[NumSrc-1:0] & {{(NumSrc-1){1'b1}}, 1'b0};
      end
      if (valid_i && we_i && addr_i == IrqMsip) begin
        msip_q <= wdata_i[0];
      end
    end
  end

  always_comb begin
    case (addr_i)
      IrqEnable:  rdata_o = DataWidth'(enable_q);
      IrqPending: rdata_o = DataWidth'(pending_q);
      IrqClaim:   rdata_o = DataWidth'(claim_id);
      IrqMsip:    rdata_o = DataWidth'(msip_q);
      default:    rdata_o = '0;
    endcase
  end

  assign irq_o  = |(pending_q & enable_q);
  assign msip_o = msip_q;

endmodule

/* logic/timer_regs.sv */
// Compare timer register block
// Free-running counter with a registered level interrupt on count >= compare
module timer_regs (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                valid_i,
  input  logic [periph_pkg::RegionSelLsb-1:0] addr_i,
  input  logic                                we_i,
  input  logic [periph_pkg::BeWidth-1:0]      be_i,
  input  logic [periph_pkg::DataWidth-1:0]    wdata_i,
  output logic [periph_pkg::DataWidth-1:0]    rdata_o,
  output logic                                intr_o
);
  import periph_pkg::*;

  logic                 en_q;
  logic [DataWidth-1:0] count_q;
  logic [DataWidth-1:0] compare_q;
  logic                 intr_q;
  logic                 wr;

  assign wr = valid_i & we_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q      <= 1'b0;
      count_q   <= '0;
      compare_q <= '1;
      intr_q    <= 1'b0;
    end else begin
      if (wr && addr_i == TimerCtrl && be_i[0]) begin
        en_q <= wdata_i[0];
      end

      // Software write takes priority over counting
      if (wr && addr_i == TimerCount) begin
        count_q <= merge_be(count_q, wdata_i, be_i);
      end else if (en_q) begin
        count_q <= count_q + 1'b1;
      end

      if (wr && addr_i == TimerCompare) begin
        compare_q <= merge_be(compare_q, wdata_i, be_i);
      end

      intr_q <= en_q & (count_q >= compare_q);
    end
  end

  always_comb begin
    case (addr_i)
      TimerCtrl:    rdata_o = DataWidth'(en_q);
      TimerCount:   rdata_o = count_q;
      TimerCompare: rdata_o = compare_q;
      default:      rdata_o = '0;
    endcase
  end

  assign intr_o = intr_q;

endmodule

/* logic/gpio_regs.sv */
// GPIO register block
// Synchronized inputs, outputs with enables, sticky rising-edge interrupts
module gpio_regs #(
  parameter int unsigned GpioWidth = 16
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                valid_i,
  input  logic [periph_pkg::RegionSelLsb-1:0] addr_i,
  input  logic                                we_i,
  input  logic [periph_pkg::BeWidth-1:0]      be_i,
  input  logic [periph_pkg::DataWidth-1:0]    wdata_i,
  output logic [periph_pkg::DataWidth-1:0]    rdata_o,
  input  logic [GpioWidth-1:0]                gpio_i,
  output logic [GpioWidth-1:0]                gpio_o,
  output logic [GpioWidth-1:0]                gpio_en_o,
  output logic [GpioWidth-1:0]                intr_o
);
  import periph_pkg::*;

  logic [GpioWidth-1:0] sync_q1;
  logic [GpioWidth-1:0] sync_q2;
  logic [GpioWidth-1:0] prev_q;
  logic [GpioWidth-1:0] out_q;
  logic [GpioWidth-1:0] oen_q;
  logic [GpioWidth-1:0] ien_q;
  logic [GpioWidth-1:0] status_q;
  logic [GpioWidth-1:0] rise;
  logic [GpioWidth-1:0] clear;
  logic                 wr;

  assign wr    = valid_i & we_i;
  assign rise  = sync_q2 & ~prev_q & ien_q;
  assign clear = (wr && addr_i == GpioIntrStatus) ? GpioWidth'(merge_be('0, wdata_i, be_i)) : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q1  <= '0;
      sync_q2  <= '0;
      prev_q   <= '0;
      out_q    <= '0;
      oen_q    <= '0;
      ien_q    <= '0;
      status_q <= '0;
    end else begin
      sync_q1  <= gpio_i;
      sync_q2  <= sync_q1;
      prev_q   <= sync_q2;
      // New edge wins over a clear in the same cycle
      status_q <= (status_q & ~clear) | rise;
      if (wr) begin
        case (addr_i)
          GpioDataOut: out_q <= GpioWidth'(merge_be(DataWidth'(out_q), wdata_i, be_i));
          GpioOutEn:   oen_q <= GpioWidth'(merge_be(DataWidth'(oen_q), wdata_i, be_i));
          GpioIntrEn:  ien_q <= GpioWidth'(merge_be(DataWidth'(ien_q), wdata_i, be_i));
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (addr_i)
      GpioDataIn:     rdata_o = DataWidth'(sync_q2);
      GpioDataOut:    rdata_o = DataWidth'(out_q);
      GpioOutEn:      rdata_o = DataWidth'(oen_q);
      GpioIntrEn:     rdata_o = DataWidth'(ien_q);
      GpioIntrStatus: rdata_o = DataWidth'(status_q);
      default:        rdata_o = '0;
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_en_o = oen_q;
  assign intr_o    = status_q;

endmodule

/* logic/reg_demux.sv */
// Register-bus address decoder and demultiplexer
// Unmapped regions and addresses above the window answer with an error
module reg_demux (
  input  logic                                                     reg_valid_i,
  input  logic [periph_pkg::AddrWidth-1:0]                         reg_addr_i,
  output logic [periph_pkg::DataWidth-1:0]                         reg_rdata_o,
  output logic                                                     reg_err_o,
  output logic [periph_pkg::NumRegions-1:0]                        sel_valid_o,
  input  logic [periph_pkg::NumRegions-1:0][periph_pkg::DataWidth-1:0] sel_rdata_i
);
  import periph_pkg::*;

  localparam int unsigned SelWidth = RegionSelMsb - RegionSelLsb + 1;

  logic [SelWidth-1:0] region;
  logic                upper_zero;
  logic                hit;

  assign region     = reg_addr_i[RegionSelMsb:RegionSelLsb];
  assign upper_zero = (reg_addr_i[AddrWidth-1:RegionSelMsb+1] == '0);

  always_comb begin
    sel_valid_o = '0;
    reg_rdata_o = '0;
    hit         = 1'b0;
    for (int i = 0; i < NumRegions; i++) begin
      if (upper_zero && (int'(region) == i)) begin
        hit            = 1'b1;
        sel_valid_o[i] = reg_valid_i;
        reg_rdata_o    = sel_rdata_i[i];
      end
    end
    // Decode error returns zero data
    reg_err_o = reg_valid_i & ~hit;
  end

endmodule

/* logic/obi_to_reg.sv */
// OBI to register-bus bridge
// Grants every request at once, response follows one cycle later
module obi_to_reg (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             req_i,
  input  logic [periph_pkg::AddrWidth-1:0] addr_i,
  input  logic                             we_i,
  input  logic [periph_pkg::BeWidth-1:0]   be_i,
  input  logic [periph_pkg::DataWidth-1:0] wdata_i,
  output logic                             gnt_o,
  output logic                             rvalid_o,
  output logic [periph_pkg::DataWidth-1:0] rdata_o,
  output logic                             err_o,
  output logic                             reg_valid_o,
  output logic [periph_pkg::AddrWidth-1:0] reg_addr_o,
  output logic                             reg_we_o,
  output logic [periph_pkg::BeWidth-1:0]   reg_be_o,
  output logic [periph_pkg::DataWidth-1:0] reg_wdata_o,
  input  logic [periph_pkg::DataWidth-1:0] reg_rdata_i,
  input  logic                             reg_err_i
);
  import periph_pkg::*;

  logic                 accept;
  logic                 rvalid_q;
  logic                 err_q;
  logic [DataWidth-1:0] rdata_q;

  // No back-pressure, grant follows request
  assign gnt_o  = req_i;
  assign accept = req_i & gnt_o;

  assign reg_valid_o = accept;
  assign reg_addr_o  = addr_i;
  assign reg_we_o    = we_i;
  assign reg_be_o    = be_i;
  assign reg_wdata_o = wdata_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= accept;
      err_q    <= accept & reg_err_i;
    end
  end

  // Write responses carry zero data
  always_ff @(posedge clk_i) begin
    if (accept) rdata_q <= we_i ? '0 : reg_rdata_i;
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;
  assign rdata_o  = rdata_q;

endmodule

/* logic/periph_pkg.sv */
// Peripheral subsystem shared definitions
// Bus widths, region map, register offsets and interrupt source numbering
package periph_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  // Region select is addr[11:8] inside a 4 KiB window
  localparam int unsigned NumRegions   = 3;
  localparam int unsigned RegionSelLsb = 8;
  localparam int unsigned RegionSelMsb = 11;

  localparam int unsigned GpioRegion  = 0;
  localparam int unsigned TimerRegion = 1;
  localparam int unsigned IrqRegion   = 2;

  localparam logic [RegionSelLsb-1:0] GpioDataIn     = 8'h00;
  localparam logic [RegionSelLsb-1:0] GpioDataOut    = 8'h04;
  localparam logic [RegionSelLsb-1:0] GpioOutEn      = 8'h08;
  localparam logic [RegionSelLsb-1:0] GpioIntrEn     = 8'h0C;
  localparam logic [RegionSelLsb-1:0] GpioIntrStatus = 8'h10;

  localparam logic [RegionSelLsb-1:0] TimerCtrl    = 8'h00;
  localparam logic [RegionSelLsb-1:0] TimerCount   = 8'h04;
  localparam logic [RegionSelLsb-1:0] TimerCompare = 8'h08;

  localparam logic [RegionSelLsb-1:0] IrqEnable  = 8'h00;
  localparam logic [RegionSelLsb-1:0] IrqPending = 8'h04;
  localparam logic [RegionSelLsb-1:0] IrqClaim   = 8'h08;
  localparam logic [RegionSelLsb-1:0] IrqMsip    = 8'h0C;

  localparam int unsigned MaxSources = 32;
  localparam int unsigned IrqIdWidth = 5;

  // Source 0 is reserved, GPIO pins start at 1
  function automatic int unsigned timer_src_id(input int unsigned gpio_width);
    return gpio_width + 1;
  endfunction

  function automatic int unsigned ext_src_base(input int unsigned gpio_width);
    return gpio_width + 2;
  endfunction

  function automatic logic [DataWidth-1:0] merge_be(input logic [DataWidth-1:0] old_data,
                                                    input logic [DataWidth-1:0] new_data,
                                                    input logic [BeWidth-1:0]   be);
    logic [DataWidth-1:0] result;
    result = old_data;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) result[8*b+:8] = new_data[8*b+:8];
    end
    return result;
  endfunction

endpackage
